/* src.f */
+incdir+source
source/alu_pkg.sv
source/alu_simple_unit.sv
source/alu_muldiv_unit.sv
source/alu_result_merge.sv
source/alu_apb_top.sv
dv/alu_checker.sv
dv/tb_alu.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the ALU testbench with Verilator
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_alu -f src.f -o tb_alu_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/tb_alu_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "STATUS: PASS" "$LOG"; then
  exit 0
fi
exit 1

/* dv/tb_alu.sv */
`timescale 1ns/1ps
`include "alu_macros.svh"

module tb_alu;

  localparam int WATCHDOG_CYCLES = 60000;

  logic        clock;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  int          cycle_count = 0;

  alu_apb_top i_alu_apb_top (.*);
  alu_checker i_checker (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock) cycle_count <= cycle_count + 1;

  // Reference results straight from the operation definitions
  function automatic logic [63:0] expected_result(alu_pkg::alu_op_e op, logic [31:0] a,
                                                  logic [31:0] b);
    logic [4:0]  sh;
    logic [31:0] r;
    sh = b[4:0];
    r  = '0;
    case (op)
      alu_pkg::OP_MUL: return 64'(a) * 64'(b);
      alu_pkg::OP_DIV: return (b == 0) ? {a, 32'hffff_ffff} : {a % b, a / b};
      alu_pkg::OP_AND: r = a & b;
      alu_pkg::OP_OR:  r = a | b;
      alu_pkg::OP_ADD: r = a + b;
      alu_pkg::OP_SUB: r = a - b;
      alu_pkg::OP_SHR: r = a >> sh;
      alu_pkg::OP_SHRA: r = $signed(a) >>> sh;
      alu_pkg::OP_SHL: r = a << sh;
      alu_pkg::OP_ROR: r = (sh == 0) ? a : ((a >> sh) | (a << (6'd32 - {1'b0, sh})));
      alu_pkg::OP_ROL: r = (sh == 0) ? a : ((a << sh) | (a >> (6'd32 - {1'b0, sh})));
      alu_pkg::OP_NEG: r = ~b + 32'd1;
      alu_pkg::OP_NOT: r = ~b;
      alu_pkg::OP_INC: r = a + 32'd1;
      default: r = '0;
    endcase
    return {32'd0, r};
  endfunction

  function automatic logic [31:0] rand_operand();
    case ($urandom_range(7, 0))
      0: return 32'd0;
      1: return 32'hffff_ffff;
      2: return 32'd1;
      3: return 32'h8000_0000;
      4: return 32'($urandom_range(15, 0));
      default: return $urandom();
    endcase
  endfunction

  // One APB transfer, setup then access, no wait states
  task automatic bus_access(input string name, input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, input logic exp_err,
                            input logic rd_check, input logic [31:0] rd_exp,
                            output logic [31:0] rdata);
    i_checker.expect_access(name, exp_err, rd_check, rd_exp);
    @(posedge clock);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clock);
    #1;
    penable = 1'b1;
    @(negedge clock);
    rdata = prdata;
    @(posedge clock);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    logic [31:0] rd;
    bus_access($sformatf("write_%02h", addr), 1'b1, addr, data, 1'b0, 1'b0, '0, rd);
  endtask

  task automatic read_expect(input string name, input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    bus_access(name, 1'b0, addr, '0, 1'b0, 1'b1, exp, rd);
  endtask

  task automatic wait_done(input string name);
    logic [31:0] status;
    int          t0;
    logic        finished;
    t0       = cycle_count;
    finished = 1'b0;
    while (!finished && (cycle_count - t0) < 100) begin
      bus_access("status_poll", 1'b0, `ALU_ADDR_STATUS, '0, 1'b0, 1'b0, '0, status);
      finished = (status[1:0] == 2'b10);  // done and not busy
    end
    if (!finished) begin
      i_checker.report_failure($sformatf("%s: STATUS never showed done within 100 cycles", name));
    end
  endtask

  task automatic check_results(input string name, input logic [63:0] exp);
    logic [31:0] rd;
    i_checker.expect_result(name, exp);
    bus_access({name, " lo"}, 1'b0, `ALU_ADDR_RES_LO, '0, 1'b0, 1'b0, '0, rd);
    bus_access({name, " hi"}, 1'b0, `ALU_ADDR_RES_HI, '0, 1'b0, 1'b0, '0, rd);
  endtask

  task automatic run_op(input string name, input alu_pkg::alu_op_e op, input logic [31:0] a,
                        input logic [31:0] b);
    write_reg(`ALU_ADDR_A, a);
    write_reg(`ALU_ADDR_B, b);
    write_reg(`ALU_ADDR_CTRL, 32'(op));
    wait_done(name);
    check_results(name, expected_result(op, a, b));
  endtask

  initial begin : watchdog
    int n;
    for (n = 0; n < WATCHDOG_CYCLES; n++) begin
      @(posedge clock);
    end
    $display("Simulation did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin : stimulus
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] rd;
    int          i;
    int          k;
    void'($urandom(32'h78b1cdba));
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (2) @(posedge clock);
    #1;
    rst_n = 1'b1;
    read_expect("status_after_reset", `ALU_ADDR_STATUS, 32'd0);

    for (k = 0; k <= 13; k++) begin
      if (k == 4 || k == 5) continue;       // MUL and DIV come later
      for (i = 0; i < 8; i++) begin
        run_op($sformatf("simple_op%0d_%0d", k, i), alu_pkg::alu_op_e'(k),
               rand_operand(), rand_operand());
      end
    end

    for (i = 0; i < 200; i++) begin
      run_op($sformatf("muldiv_%0d", i),
             ($urandom_range(1, 0) == 1) ? alu_pkg::OP_MUL : alu_pkg::OP_DIV,
             rand_operand(), rand_operand());
    end

    // Busy window with a rejected CTRL write
    a = $urandom();
    b = $urandom();
    write_reg(`ALU_ADDR_A, a);
    write_reg(`ALU_ADDR_B, b);
    write_reg(`ALU_ADDR_CTRL, 32'(alu_pkg::OP_MUL));
    read_expect("status_busy", `ALU_ADDR_STATUS, 32'd1);
    bus_access("ctrl_while_busy", 1'b1, `ALU_ADDR_CTRL, 32'(alu_pkg::OP_ADD), 1'b1, 1'b0, '0, rd);
    wait_done("mul_after_reject");
    check_results("mul_after_reject", expected_result(alu_pkg::OP_MUL, a, b));
    read_expect("status_done", `ALU_ADDR_STATUS, 32'd2);

    // Illegal opcodes while idle
    bus_access("illegal_op_14", 1'b1, `ALU_ADDR_CTRL, 32'd14, 1'b1, 1'b0, '0, rd);
    bus_access("illegal_op_15", 1'b1, `ALU_ADDR_CTRL, 32'd15, 1'b1, 1'b0, '0, rd);
    check_results("mul_after_illegal", expected_result(alu_pkg::OP_MUL, a, b));
    read_expect("status_after_illegal", `ALU_ADDR_STATUS, 32'd2);

    // Operands rewritten mid-run
    write_reg(`ALU_ADDR_CTRL, 32'(alu_pkg::OP_DIV));
    write_reg(`ALU_ADDR_A, ~a);
    write_reg(`ALU_ADDR_B, b >> 3);
    wait_done("div_rewrite");
    check_results("div_rewrite", expected_result(alu_pkg::OP_DIV, a, b));
    write_reg(`ALU_ADDR_CTRL, 32'(alu_pkg::OP_ADD));   // Uses the rewritten A and B
    wait_done("add_new_operands");
    check_results("add_new_operands", expected_result(alu_pkg::OP_ADD, ~a, b >> 3));

    bus_access("unmapped_read", 1'b0, 8'h18, '0, 1'b1, 1'b0, '0, rd);
    bus_access("unmapped_write", 1'b1, 8'h40, $urandom(), 1'b1, 1'b0, '0, rd);
    bus_access("unaligned_read", 1'b0, 8'h02, '0, 1'b1, 1'b0, '0, rd);

    i_checker.print_summary();
    if (i_checker.errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* dv/alu_checker.sv */
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu_checker (
  input logic        clock,
  input logic        rst_n,
  input logic        psel,
  input logic        penable,
  input logic        pwrite,
  input logic [7:0]  paddr,
  input logic [31:0] prdata,
  input logic        pready,
  input logic        pslverr
);

  int          errors = 0;
  int          checks = 0;
  string       acc_name = "idle";
  logic        acc_err = 1'b0;         // Expected pslverr of the next access
  logic        acc_rd_check = 1'b0;
  logic [31:0] acc_rd_exp = '0;
  string       res_name = "none";
  logic        res_valid = 1'b0;
  logic [31:0] res_hi_exp = '0;
  logic [31:0] res_lo_exp = '0;

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic expect_access(input string name, input logic err, input logic rd_check,
                               input logic [31:0] rd_exp);
    acc_name     = name;
    acc_err      = err;
    acc_rd_check = rd_check;
    acc_rd_exp   = rd_exp;
  endtask

  task automatic expect_result(input string name, input logic [63:0] exp);
    res_name   = name;
    res_hi_exp = exp[63:32];
    res_lo_exp = exp[31:0];
    res_valid  = 1'b1;
  endtask

  task automatic report_failure(input string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic print_summary();
    $display("Checks: %0d, errors: %0d", checks, errors);
  endtask

  // Access phase sampled mid-cycle, inputs settle 1 ns after the edge
  always @(negedge clock) begin
    if (rst_n && psel && penable) begin
      compare({acc_name, " pready"}, 32'd1, {31'd0, pready});
      compare({acc_name, " pslverr"}, {31'd0, acc_err}, {31'd0, pslverr});
      if (!pwrite && acc_rd_check) begin
        compare(acc_name, acc_rd_exp, prdata);
      end
      if (!pwrite && res_valid && paddr == `ALU_ADDR_RES_LO) begin
        compare({res_name, " res_lo"}, res_lo_exp, prdata);
      end
      if (!pwrite && res_valid && paddr == `ALU_ADDR_RES_HI) begin
        compare({res_name, " res_hi"}, res_hi_exp, prdata);
      end
      acc_name     = "idle";
      acc_err      = 1'b0;
      acc_rd_check = 1'b0;
    end
  end

endmodule

/* source/alu_apb_top.sv */
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu_apb_top (
  input  logic                    clock,
  input  logic                    rst_n,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  logic [7:0]              paddr,
  input  logic [`ALU_DATA_W-1:0]  pwdata,
  output logic [`ALU_DATA_W-1:0]  prdata,
  output logic                    pready,
  output logic                    pslverr
);

  logic [`ALU_DATA_W-1:0] a_q;
  logic [`ALU_DATA_W-1:0] b_q;
  alu_pkg::alu_op_e       op_q;
  logic                   start;

  logic [`ALU_DATA_W-1:0] simple_result;
  logic [`ALU_DATA_W-1:0] md_hi;
  logic [`ALU_DATA_W-1:0] md_lo;
  logic                   md_done;
  logic [`ALU_DATA_W-1:0] res_hi;
  logic [`ALU_DATA_W-1:0] res_lo;
  logic                   busy;
  logic                   done;

  logic access;
  logic wr;
  logic addr_hit;
  logic ctrl_sel;
  logic op_illegal;
  logic ctrl_ok;

  assign access     = psel && penable;                // APB access phase
  assign wr         = access && pwrite;
  assign ctrl_sel   = (paddr == `ALU_ADDR_CTRL);
  assign op_illegal = (pwdata[3:0] > 4'(alu_pkg::OP_INC));
  assign ctrl_ok    = wr && ctrl_sel && !busy && !op_illegal;

  assign pready  = 1'b1;                              // No wait states
  assign pslverr = access && (!addr_hit ||
                   (pwrite && ctrl_sel && (busy || op_illegal)));

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      a_q   <= '0;
      b_q   <= '0;
      op_q  <= alu_pkg::OP_AND;
      start <= 1'b0;
    end else begin
      start <= ctrl_ok;                               // One-cycle pulse
      if (wr && (paddr == `ALU_ADDR_A)) begin
        a_q <= pwdata;
      end
      if (wr && (paddr == `ALU_ADDR_B)) begin
        b_q <= pwdata;
      end
      if (ctrl_ok) begin
        op_q <= alu_pkg::alu_op_e'(pwdata[3:0]);
      end
    end
  end

  // Read mux and address decode
  always_comb begin
    addr_hit = 1'b1;
    case (paddr)
      `ALU_ADDR_A:      prdata = a_q;
      `ALU_ADDR_B:      prdata = b_q;
      `ALU_ADDR_CTRL:   prdata = {{(`ALU_DATA_W-4){1'b0}}, op_q};
      `ALU_ADDR_STATUS: prdata = {{(`ALU_DATA_W-2){1'b0}}, done, busy};
      `ALU_ADDR_RES_LO: prdata = res_lo;
      `ALU_ADDR_RES_HI: prdata = res_hi;
      default: begin
        prdata   = '0;
        addr_hit = 1'b0;
      end
    endcase
  end

  alu_simple_unit i_simple (
    .opcode (op_q),
    .a      (a_q),
    .b      (b_q),
    .result (simple_result)
  );

  alu_muldiv_unit i_muldiv (
    .clock  (clock),
    .rst_n  (rst_n),
    .start  (start),
    .opcode (op_q),
    .a      (a_q),
    .b      (b_q),
    .hi     (md_hi),
    .lo     (md_lo),
    .done   (md_done)
  );

  alu_result_merge i_merge (
    .clock         (clock),
    .rst_n         (rst_n),
    .start         (start),
    .opcode        (op_q),
    .simple_result (simple_result),
    .md_hi         (md_hi),
    .md_lo         (md_lo),
    .md_done       (md_done),
    .res_hi        (res_hi),
    .res_lo        (res_lo),
    .busy          (busy),
    .done          (done)
  );

endmodule

/* source/alu_result_merge.sv */
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu_result_merge (
  input  logic                    clock,
  input  logic                    rst_n,
  input  logic                    start,
  input  alu_pkg::alu_op_e        opcode,
  input  logic [`ALU_DATA_W-1:0]  simple_result,
  input  logic [`ALU_DATA_W-1:0]  md_hi,
  input  logic [`ALU_DATA_W-1:0]  md_lo,
  input  logic                    md_done,
  output logic [`ALU_DATA_W-1:0]  res_hi,
  output logic [`ALU_DATA_W-1:0]  res_lo,
  output logic                    busy,
  output logic                    done
);

  logic md_op;

  assign md_op = (opcode == alu_pkg::OP_MUL) || (opcode == alu_pkg::OP_DIV);

  // busy holds the multicycle class latched at start
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      res_hi <= '0;
      res_lo <= '0;
      busy   <= 1'b0;
      done   <= 1'b0;
    end else if (start) begin
      if (md_op) begin
        busy <= 1'b1;
        done <= 1'b0;                       // Cleared until md_done
      end else begin
        res_hi <= '0;
        res_lo <= simple_result;
        done   <= 1'b1;
      end
    end else if (busy && md_done) begin
      res_hi <= md_hi;
      res_lo <= md_lo;
      busy   <= 1'b0;
      done   <= 1'b1;
    end
  end

  a_busy_done_excl: assert property (
    @(posedge clock) disable iff (!rst_n)
    !(busy && done)
  );

  a_md_done_busy: assert property (
    @(posedge clock) disable iff (!rst_n)
    md_done |-> busy
  );

  // Multicycle latency seen from this side of the units
  a_md_latency: assert property (
    @(posedge clock) disable iff (!rst_n)
    (start && md_op) |-> ##(`ALU_MULDIV_CYCLES + 1) md_done
  );

endmodule

/* source/alu_muldiv_unit.sv */
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu_muldiv_unit (
  input  logic                    clock,
  input  logic                    rst_n,
  input  logic                    start,
  input  alu_pkg::alu_op_e        opcode,
  input  logic [`ALU_DATA_W-1:0]  a,
  input  logic [`ALU_DATA_W-1:0]  b,
  output logic [`ALU_DATA_W-1:0]  hi,
  output logic [`ALU_DATA_W-1:0]  lo,
  output logic                    done
);

  localparam int CNT_W = $clog2(`ALU_MULDIV_CYCLES);

  alu_pkg::muldiv_state_e state;

  logic [`ALU_DATA_W-1:0] hi_q;          // Product high or remainder
  logic [`ALU_DATA_W-1:0] lo_q;          // Multiplier/product low or quotient
  logic [`ALU_DATA_W-1:0] b_q;           // Multiplicand or divisor
  logic [CNT_W-1:0]       count;
  logic                   last_iter;
  logic                   is_mul;
  logic                   is_div;

  logic [`ALU_DATA_W:0]   mul_sum;
  logic [`ALU_DATA_W:0]   div_shift;
  logic [`ALU_DATA_W:0]   div_diff;
  logic                   div_ge;
  logic [`ALU_DATA_W-1:0] div_rem;

  assign is_mul    = (opcode == alu_pkg::OP_MUL);
  assign is_div    = (opcode == alu_pkg::OP_DIV);
  assign last_iter = (count == CNT_W'(`ALU_MULDIV_CYCLES - 1));

  // Shift-add step, carry kept for the right shift
  assign mul_sum = lo_q[0] ? ({1'b0, hi_q} + {1'b0, b_q}) : {1'b0, hi_q};

  // Restoring step, next dividend bit comes from the top of lo_q
  assign div_shift = {hi_q, lo_q[`ALU_DATA_W-1]};
  assign div_diff  = div_shift - {1'b0, b_q};
  assign div_ge    = (div_shift >= {1'b0, b_q});   // Always true for b of zero
  assign div_rem   = div_ge ? div_diff[`ALU_DATA_W-1:0] : div_shift[`ALU_DATA_W-1:0];

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state <= alu_pkg::IDLE;
      hi_q  <= '0;
      lo_q  <= '0;
      b_q   <= '0;
      count <= '0;
    end else begin
      case (state)
        alu_pkg::IDLE: begin
          if (start && (is_mul || is_div)) begin
            hi_q  <= '0;
            lo_q  <= a;
            b_q   <= b;
            count <= '0;
            state <= is_mul ? alu_pkg::MUL_RUN : alu_pkg::DIV_RUN;
          end
        end
        alu_pkg::MUL_RUN: begin
          {hi_q, lo_q} <= {mul_sum, lo_q[`ALU_DATA_W-1:1]};
          count        <= count + 1'b1;
          if (last_iter) begin
            state <= alu_pkg::FINISH;
          end
        end
        alu_pkg::DIV_RUN: begin
          hi_q  <= div_rem;
          lo_q  <= {lo_q[`ALU_DATA_W-2:0], div_ge};
          count <= count + 1'b1;
          if (last_iter) begin
            state <= alu_pkg::FINISH;
          end
        end
        alu_pkg::FINISH: begin
          state <= alu_pkg::IDLE;             // Result held in hi_q/lo_q
        end
        default: begin
          state <= alu_pkg::IDLE;
        end
      endcase
    end
  end

  assign hi   = hi_q;
  assign lo   = lo_q;
  assign done = (state == alu_pkg::FINISH);

  // The top level must block CTRL writes until the previous run has drained
  a_start_in_idle: assert property (
    @(posedge clock) disable iff (!rst_n)
    start |-> (state == alu_pkg::IDLE)
  );

endmodule

/* source/alu_simple_unit.sv */
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu_simple_unit (
  input  alu_pkg::alu_op_e        opcode,
  input  logic [`ALU_DATA_W-1:0]  a,
  input  logic [`ALU_DATA_W-1:0]  b,
  output logic [`ALU_DATA_W-1:0]  result
);

  logic [4:0]                 sh;
  logic [2*`ALU_DATA_W-1:0]   a_pair;
  logic [2*`ALU_DATA_W-1:0]   ror_pair;
  logic [2*`ALU_DATA_W-1:0]   rol_pair;

  assign sh     = b[4:0];                   // Shift and rotate amount
  assign a_pair = {a, a};

  // Rotates taken from a doubled copy of a
  assign ror_pair = a_pair >> sh;
  assign rol_pair = a_pair << sh;

  always_comb begin
    case (opcode)
      alu_pkg::OP_AND: begin
        result = a & b;
      end
      alu_pkg::OP_OR: begin
        result = a | b;
      end
      alu_pkg::OP_ADD: begin
        result = a + b;
      end
      alu_pkg::OP_SUB: begin
        result = a - b;
      end
      alu_pkg::OP_SHR: begin
        result = a >> sh;
      end
      alu_pkg::OP_SHRA: begin
        result = $signed(a) >>> sh;           // Sign fill
      end
      alu_pkg::OP_SHL: begin
        result = a << sh;
      end
      alu_pkg::OP_ROR: begin
        result = ror_pair[`ALU_DATA_W-1:0];
      end
      alu_pkg::OP_ROL: begin
        result = rol_pair[2*`ALU_DATA_W-1:`ALU_DATA_W];
      end
      alu_pkg::OP_NEG: begin
        result = -b;                          // Two's complement of b
      end
      alu_pkg::OP_NOT: begin
        result = ~b;
      end
      alu_pkg::OP_INC: begin
        result = a + 1'b1;
      end
      default: begin
        result = '0;                          // MUL, DIV and illegal codes
      end
    endcase
  end

endmodule

/* source/alu_pkg.sv */
package alu_pkg;

  // Opcode written to CTRL[3:0], codes 14 and 15 are illegal
  typedef enum logic [3:0] {
    OP_AND  = 4'd0,
    OP_OR   = 4'd1,
    OP_ADD  = 4'd2,
    OP_SUB  = 4'd3,
    OP_MUL  = 4'd4,
    OP_DIV  = 4'd5,
    OP_SHR  = 4'd6,
    OP_SHRA = 4'd7,
    OP_SHL  = 4'd8,
    OP_ROR  = 4'd9,
    OP_ROL  = 4'd10,
    OP_NEG  = 4'd11,
    OP_NOT  = 4'd12,
    OP_INC  = 4'd13
  } alu_op_e;

  // Multicycle unit sequencing
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    MUL_RUN = 2'd1,
    DIV_RUN = 2'd2,
    FINISH  = 2'd3
  } muldiv_state_e;

endpackage

/* source/alu_macros.svh */
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// Operand and result word width
`define ALU_DATA_W 32

// APB register byte offsets
`define ALU_ADDR_A      8'h00
`define ALU_ADDR_B      8'h04
`define ALU_ADDR_CTRL   8'h08
`define ALU_ADDR_STATUS 8'h0C
`define ALU_ADDR_RES_LO 8'h10
`define ALU_ADDR_RES_HI 8'h14

// Iterations of the shift-add multiply and restoring divide
`define ALU_MULDIV_CYCLES 32

`endif
